/* Bender.yml */
package:
  name: rvseed_mem

sources:
  # RTL
  - include_dirs:
      - src
    files:
      - src/rvseed_mem_pkg.sv
      - src/mem_sram.sv
      - src/axi_slave.sv
      - src/axi_master_bridge.sv
      - src/rvseed_mem_top.sv
  # testbench
  - target: test
    include_dirs:
      - src
    files:
      - testbench/rvseed_mem_assertions.sv
      - testbench/tb_rvseed_mem.sv

/* rvseed_mem.f */
+incdir+src
src/rvseed_mem_pkg.sv
src/mem_sram.sv
src/axi_slave.sv
src/axi_master_bridge.sv
src/rvseed_mem_top.sv
testbench/rvseed_mem_assertions.sv
testbench/tb_rvseed_mem.sv

/* src/axi_master_bridge.sv */
`timescale 1ns/1ns
`include "rvseed_macros.svh"

module axi_master_bridge
  import rvseed_mem_pkg::*;
(
  input  logic      clock,
  input  logic      reset_n,
  // four-phase core port
  input  logic      req_i,
  input  core_cmd_t cmd_i,
  output logic      ack_o,
  output core_rsp_t rsp_o,
  // manager side of the AXI channels
  output axi_ar_t   ar_o,
  output logic      ar_valid_o,
  input  logic      ar_ready_i,
  input  axi_r_t    r_i,
  input  logic      r_valid_i,
  output logic      r_ready_o,
  output axi_aw_t   aw_o,
  output logic      aw_valid_o,
  input  logic      aw_ready_i,
  output axi_w_t    w_o,
  output logic      w_valid_o,
  input  logic      w_ready_i,
  input  axi_b_t    b_i,
  input  logic      b_valid_i,
  output logic      b_ready_o
);

  localparam int BEAT_W = $clog2(`RV_LINE_BEATS);

  typedef enum logic [2:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_RESP, ST_ACK} state_e;

  state_e            state;
  logic              ack_q;
  core_rsp_t         rsp_q;
  logic [BEAT_W-1:0] beat_q;
  logic              is_write, is_line;
  logic [7:0]        burst_len;
  logic              ar_hs, r_hs, aw_hs, w_hs, b_hs;

  // command decode, cmd_i is stable for the whole transaction
  assign is_write  = cmd_i.kind inside {WRITE_WORD, WRITE_LINE};
  assign is_line   = cmd_i.kind inside {READ_LINE, WRITE_LINE};
  assign burst_len = is_line ? 8'(`RV_LINE_BEATS - 1) : 8'd0;

  assign ar_hs = ar_valid_o && ar_ready_i;
  assign r_hs  = r_valid_i && r_ready_o;
  assign aw_hs = aw_valid_o && aw_ready_i;
  assign w_hs  = w_valid_o && w_ready_i;
  assign b_hs  = b_valid_i && b_ready_o;

  // address channels
  assign ar_o.addr  = cmd_i.addr;
  assign ar_o.len   = burst_len;
  assign ar_o.size  = AXI_SIZE_DW;
  assign ar_o.burst = BURST_INCR;
  assign aw_o.addr  = cmd_i.addr;
  assign aw_o.len   = burst_len;
  assign aw_o.size  = AXI_SIZE_DW;
  assign aw_o.burst = BURST_INCR;
  assign ar_valid_o = (state == ST_ADDR) && !is_write;
  assign aw_valid_o = (state == ST_ADDR) && is_write;

  // write beats from wline, full strobes for a line
  assign w_o.data  = cmd_i.wline[beat_q];
  assign w_o.strb  = is_line ? '1 : cmd_i.wstrb;
  assign w_o.last  = beat_q == burst_len[BEAT_W-1:0];
  assign w_valid_o = (state == ST_DATA) && is_write;

  // always ready while waiting for R or B
  assign r_ready_o = (state == ST_DATA) && !is_write;
  assign b_ready_o = state == ST_RESP;

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state <= ST_IDLE;
      ack_q <= 1'b0;
    end else begin
      // rises a cycle into ACK, falls a cycle after req drops
      ack_q <= (state == ST_ACK) && req_i;
      case (state)
        ST_IDLE: if (req_i) state <= ST_ADDR;
        ST_ADDR: if (ar_hs || aw_hs) state <= ST_DATA;
        ST_DATA: begin
          if (r_hs && r_i.last) begin
            state <= ST_ACK;
          end else if (w_hs && w_o.last) begin
            state <= ST_RESP;
          end
        end
        ST_RESP: if (b_hs) state <= ST_ACK;
        // hold until the core closes the handshake
        ST_ACK:  if (ack_q && !req_i) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // beat counter and response gathering
  always_ff @(posedge clock) begin
    if (state == ST_IDLE && req_i) begin
      rsp_q.rline <= '0;
      rsp_q.resp  <= OKAY;
    end
    if (ar_hs || aw_hs) begin
      beat_q <= '0;
    end else if (r_hs || w_hs) begin
      beat_q <= beat_q + 1'b1;
    end
    if (r_hs) begin
      rsp_q.rline[beat_q] <= r_i.data;
      // keep the worst beat response
      if (r_i.resp > rsp_q.resp) begin
        rsp_q.resp <= r_i.resp;
      end
    end
    if (b_hs && (b_i.resp > rsp_q.resp)) begin
      rsp_q.resp <= b_i.resp;
    end
  end

endmodule

/* src/axi_slave.sv */
`timescale 1ns/1ns
`include "rvseed_macros.svh"

module axi_slave
  import rvseed_mem_pkg::*;
(
  input  logic    clock,
  input  logic    reset_n,
  // read address
  input  axi_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  // read data
  output axi_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  // write address
  input  axi_aw_t aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  // write data
  input  axi_w_t  w_i,
  input  logic    w_valid_i,
  output logic    w_ready_o,
  // write response
  output axi_b_t  b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i
);

  localparam int IDX_W = $clog2(`RV_MEM_WORDS);
  localparam int BYTE_SH = $clog2(`RV_DATA_W / 8);
  localparam logic [`RV_ADDR_W-1:0] BEAT_BYTES = `RV_DATA_W / 8;
  localparam logic [`RV_ADDR_W-1:0] WIN_BYTES = (`RV_DATA_W / 8) * `RV_MEM_WORDS;

  typedef enum logic [1:0] {R_IDLE, R_FETCH, R_DATA} rd_state_e;
  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_e;

  rd_state_e               r_state, r_state_n;
  wr_state_e               w_state, w_state_n;
  logic                    addr_ready_q;
  logic                    r_valid_q, w_ready_q, b_valid_q;
  logic [`RV_ADDR_W-1:0]   rd_addr_q, wr_addr_q, rd_req_addr;
  logic [7:0]              rd_len_q, rd_beat_q;
  logic                    rd_err_q, wr_err_q;
  logic                    rd_issue, rd_last;
  logic                    ar_hs, r_hs, aw_hs, w_hs, b_hs;
  // registered SRAM request
  logic                    mem_en_q, mem_we_q;
  logic [IDX_W-1:0]        mem_index_q;
  logic [`RV_DATA_W-1:0]   mem_wdata_q, mem_rdata;
  logic [`RV_DATA_W/8-1:0] mem_strb_q;

  // unsigned offset wraps for addresses below the base
  function automatic logic in_window(input logic [`RV_ADDR_W-1:0] addr);
    return (addr - `RV_MEM_BASE) < WIN_BYTES;
  endfunction

  function automatic logic [IDX_W-1:0] word_index(input logic [`RV_ADDR_W-1:0] addr);
    logic [`RV_ADDR_W-1:0] offset;
    offset = addr - `RV_MEM_BASE;
    return offset[IDX_W+BYTE_SH-1:BYTE_SH];
  endfunction

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // one address accepted at a time, AR wins a tie
  assign ar_ready_o = addr_ready_q;
  assign aw_ready_o = addr_ready_q && !ar_valid_i;
  assign r_valid_o  = r_valid_q;
  assign w_ready_o  = w_ready_q;
  assign b_valid_o  = b_valid_q;

  // read FSM, any burst type walks as INCR
  always_comb begin
    r_state_n = r_state;
    case (r_state)
      R_IDLE:  if (ar_hs) r_state_n = R_FETCH;
      R_FETCH: r_state_n = R_DATA;
      R_DATA:  if (r_hs && rd_last) r_state_n = R_IDLE;
      default: r_state_n = R_IDLE;
    endcase
  end

  // write FSM, burst ends on W last
  always_comb begin
    w_state_n = w_state;
    case (w_state)
      W_IDLE:  if (aw_hs) w_state_n = W_DATA;
      W_DATA:  if (w_hs && w_i.last) w_state_n = W_RESP;
      W_RESP:  if (b_hs) w_state_n = W_IDLE;
      default: w_state_n = W_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      r_state      <= R_IDLE;
      w_state      <= W_IDLE;
      addr_ready_q <= 1'b0;
      r_valid_q    <= 1'b0;
      w_ready_q    <= 1'b0;
      b_valid_q    <= 1'b0;
    end else begin
      r_state      <= r_state_n;
      w_state      <= w_state_n;
      addr_ready_q <= (r_state_n == R_IDLE) && (w_state_n == W_IDLE);
      // valid waits one cycle for the SRAM read of each beat
      if (r_state == R_DATA && !r_valid_q) begin
        r_valid_q <= 1'b1;
      end else if (r_hs) begin
        r_valid_q <= 1'b0;
      end
      // W ready one cycle after AW
      if (w_state == W_DATA && !w_ready_q) begin
        w_ready_q <= 1'b1;
      end else if (w_hs && w_i.last) begin
        w_ready_q <= 1'b0;
      end
      // B follows the cycle the last write lands in the SRAM
      if (w_state == W_RESP && !b_valid_q) begin
        b_valid_q <= 1'b1;
      end else if (b_hs) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // first beat issues from FETCH, later beats on the R transfer
  assign rd_last     = rd_beat_q == rd_len_q;
  assign rd_issue    = (r_state == R_FETCH) || (r_hs && !rd_last);
  assign rd_req_addr = (r_state == R_FETCH) ? rd_addr_q : rd_addr_q + BEAT_BYTES;

  // burst address and beat tracking
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      rd_addr_q <= ar_i.addr;
      rd_len_q  <= ar_i.len;
      rd_beat_q <= '0;
    end else if (r_hs) begin
      rd_addr_q <= rd_req_addr;
      rd_beat_q <= rd_beat_q + 8'd1;
    end
    if (aw_hs) begin
      wr_addr_q <= aw_i.addr;
      wr_err_q  <= 1'b0;
    end else if (w_hs) begin
      wr_addr_q <= wr_addr_q + BEAT_BYTES;
      // sticky over the burst
      wr_err_q  <= wr_err_q || !in_window(wr_addr_q);
    end
  end

  // out-of-window beats never enable the SRAM
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mem_en_q <= 1'b0;
    end else if (rd_issue) begin
      mem_en_q <= in_window(rd_req_addr);
    end else if (w_hs) begin
      mem_en_q <= in_window(wr_addr_q);
    end else begin
      mem_en_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_issue) begin
      mem_we_q    <= 1'b0;
      mem_index_q <= word_index(rd_req_addr);
      rd_err_q    <= !in_window(rd_req_addr);
    end else if (w_hs) begin
      mem_we_q    <= 1'b1;
      mem_index_q <= word_index(wr_addr_q);
      mem_wdata_q <= w_i.data;
      mem_strb_q  <= w_i.strb;
    end
  end

  // error beats return zero data
  assign r_o.data = rd_err_q ? '0 : mem_rdata;
  assign r_o.resp = rd_err_q ? SLVERR : OKAY;
  assign r_o.last = rd_last;
  assign b_o.resp = wr_err_q ? SLVERR : OKAY;

  mem_sram i_mem_sram (
    .clock   (clock),
    .en_i    (mem_en_q),
    .we_i    (mem_we_q),
    .index_i (mem_index_q),
    .wdata_i (mem_wdata_q),
    .strb_i  (mem_strb_q),
    .rdata_o (mem_rdata)
  );

endmodule

/* src/mem_sram.sv */
`timescale 1ns/1ns
`include "rvseed_macros.svh"

module mem_sram (
  input  logic                              clock,
  // access enable, read when we_i is low
  input  logic                              en_i,
  input  logic                              we_i,
  // doubleword index inside the window
  input  logic [$clog2(`RV_MEM_WORDS)-1:0]  index_i,
  input  logic [`RV_DATA_W-1:0]             wdata_i,
  // one bit per byte lane
  input  logic [`RV_DATA_W/8-1:0]           strb_i,
  // valid one cycle after a read enable
  output logic [`RV_DATA_W-1:0]             rdata_o
);

  localparam int LANES = `RV_DATA_W / 8;

  // storage array
  logic [`RV_DATA_W-1:0] mem [`RV_MEM_WORDS];

  // byte-lane writes
  always_ff @(posedge clock) begin
    if (en_i && we_i) begin
      for (int b = 0; b < LANES; b++) begin
        if (strb_i[b]) begin
          mem[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // registered read port
  // output holds its value until the next read
  always_ff @(posedge clock) begin
    if (en_i && !we_i) begin
      rdata_o <= mem[index_i];
    end
  end

endmodule

/* src/rvseed_macros.svh */
`ifndef RVSEED_MACROS_SVH
`define RVSEED_MACROS_SVH

// core address width in bits
`define RV_ADDR_W 32

// data width of the core port and every AXI beat
`define RV_DATA_W 64

// on-chip SRAM depth in doublewords
`define RV_MEM_WORDS 1024

// first byte of the memory window
`define RV_MEM_BASE 32'h8000_0000

// doublewords per 32-byte line
`define RV_LINE_BEATS 4

`endif

/* src/rvseed_mem_pkg.sv */
`include "rvseed_macros.svh"

package rvseed_mem_pkg;

  // what the core asks for
  typedef enum logic [1:0] {
    READ_WORD,
    WRITE_WORD,
    READ_LINE,
    WRITE_LINE
  } cmd_kind_e;

  // AXI response codes, ordered so the larger value is the worse one
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // only INCR bursts are issued
  localparam logic [1:0] BURST_INCR = 2'b01;
  // every beat carries a full doubleword
  localparam logic [2:0] AXI_SIZE_DW = 3'($clog2(`RV_DATA_W / 8));

  // core command, held stable while req is high
  typedef struct packed {
    cmd_kind_e                                   kind;
    logic [`RV_ADDR_W-1:0]                       addr;
    logic [`RV_DATA_W/8-1:0]                     wstrb;
    // word write uses doubleword 0 only
    logic [`RV_LINE_BEATS-1:0][`RV_DATA_W-1:0]   wline;
  } core_cmd_t;

  typedef struct packed {
    // word read fills doubleword 0 only
    logic [`RV_LINE_BEATS-1:0][`RV_DATA_W-1:0]   rline;
    axi_resp_e                                   resp;
  } core_rsp_t;

  typedef struct packed {
    logic [`RV_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_ar_t;

  typedef struct packed {
    logic [`RV_ADDR_W-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`RV_DATA_W-1:0]   data;
    logic [`RV_DATA_W/8-1:0] strb;
    logic                    last;
  } axi_w_t;

  typedef struct packed {
    logic [`RV_DATA_W-1:0] data;
    axi_resp_e             resp;
    logic                  last;
  } axi_r_t;

  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

endpackage

/* src/rvseed_mem_top.sv */
`timescale 1ns/1ns

module rvseed_mem_top
  import rvseed_mem_pkg::*;
(
  input  logic      clock,
  input  logic      reset_n,
  // four-phase core port
  input  logic      req_i,
  input  core_cmd_t cmd_i,
  output logic      ack_o,
  output core_rsp_t rsp_o
);

  // internal AXI channels
  axi_ar_t ar;
  logic    ar_valid, ar_ready;
  axi_r_t  r;
  logic    r_valid, r_ready;
  axi_aw_t aw;
  logic    aw_valid, aw_ready;
  axi_w_t  w;
  logic    w_valid, w_ready;
  axi_b_t  b;
  logic    b_valid, b_ready;

  // core commands to AXI bursts
  axi_master_bridge i_axi_master_bridge (
    .clock      (clock),
    .reset_n    (reset_n),
    .req_i      (req_i),
    .cmd_i      (cmd_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o),
    .ar_o       (ar),
    .ar_valid_o (ar_valid),
    .ar_ready_i (ar_ready),
    .r_i        (r),
    .r_valid_i  (r_valid),
    .r_ready_o  (r_ready),
    .aw_o       (aw),
    .aw_valid_o (aw_valid),
    .aw_ready_i (aw_ready),
    .w_o        (w),
    .w_valid_o  (w_valid),
    .w_ready_i  (w_ready),
    .b_i        (b),
    .b_valid_i  (b_valid),
    .b_ready_o  (b_ready)
  );

  // slave with the SRAM behind it
  axi_slave i_axi_slave (
    .clock      (clock),
    .reset_n    (reset_n),
    .ar_i       (ar),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .aw_i       (aw),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .w_i        (w),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .b_o        (b),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready)
  );

endmodule

/* testbench/rvseed_mem_assertions.sv */
`timescale 1ns/1ns

module rvseed_mem_assertions
  import rvseed_mem_pkg::*;
(
  input logic    clock,
  input logic    reset_n,
  // four-phase core port
  input logic    req_i,
  input logic    ack_i,
  // AXI channels between bridge and slave
  input axi_ar_t ar_i,
  input logic    ar_valid_i,
  input logic    ar_ready_i,
  input axi_r_t  r_i,
  input logic    r_valid_i,
  input logic    r_ready_i,
  input axi_aw_t aw_i,
  input logic    aw_valid_i,
  input logic    aw_ready_i,
  input axi_w_t  w_i,
  input logic    w_valid_i,
  input logic    w_ready_i,
  input axi_b_t  b_i,
  input logic    b_valid_i,
  input logic    b_ready_i
);

  // failed assertions so far
  int n_failed = 0;

  // stalled valid stays up with a frozen payload
  ar_hold_a: assert property (@(posedge clock) disable iff (!reset_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else begin
      $error("AR valid dropped or payload changed before the transfer");
      n_failed++;
    end

  aw_hold_a: assert property (@(posedge clock) disable iff (!reset_n)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
    else begin
      $error("AW valid dropped or payload changed before the transfer");
      n_failed++;
    end

  w_hold_a: assert property (@(posedge clock) disable iff (!reset_n)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
    else begin
      $error("W valid dropped or payload changed before the transfer");
      n_failed++;
    end

  r_hold_a: assert property (@(posedge clock) disable iff (!reset_n)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else begin
      $error("R valid dropped or payload changed before the transfer");
      n_failed++;
    end

  b_hold_a: assert property (@(posedge clock) disable iff (!reset_n)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else begin
      $error("B valid dropped or payload changed before the transfer");
      n_failed++;
    end

  // ack only answers a live request
  ack_rise_a: assert property (@(posedge clock) disable iff (!reset_n)
    $rose(ack_i) |-> req_i)
    else begin
      $error("ack rose while req was low");
      n_failed++;
    end

  // ack drops a cycle after req
  ack_fall_a: assert property (@(posedge clock) disable iff (!reset_n)
    $fell(ack_i) |-> !req_i && !$past(req_i))
    else begin
      $error("ack fell before req had fallen");
      n_failed++;
    end

endmodule

bind rvseed_mem_top rvseed_mem_assertions i_rvseed_mem_assertions (
  .clock      (clock),
  .reset_n    (reset_n),
  .req_i      (req_i),
  .ack_i      (ack_o),
  .ar_i       (ar),
  .ar_valid_i (ar_valid),
  .ar_ready_i (ar_ready),
  .r_i        (r),
  .r_valid_i  (r_valid),
  .r_ready_i  (r_ready),
  .aw_i       (aw),
  .aw_valid_i (aw_valid),
  .aw_ready_i (aw_ready),
  .w_i        (w),
  .w_valid_i  (w_valid),
  .w_ready_i  (w_ready),
  .b_i        (b),
  .b_valid_i  (b_valid),
  .b_ready_i  (b_ready)
);

/* testbench/tb_rvseed_mem.sv */
`timescale 1ns/1ns
`include "rvseed_macros.svh"

module tb_rvseed_mem
  import rvseed_mem_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  localparam int WORDS = `RV_MEM_WORDS;
  localparam int LINES = `RV_MEM_WORDS / `RV_LINE_BEATS;
  localparam logic [`RV_ADDR_W-1:0] WIN_BYTES = WORDS * (`RV_DATA_W / 8);
  // fill and full readback are one command per line, the rest under 64
  localparam int N_CMDS = 2 * LINES + 64;
  // a line command needs under 20 cycles
  localparam int CMD_CYCLES = 24;
  localparam int TIMEOUT_CYCLES = N_CMDS * CMD_CYCLES + 1000;

  logic      clock;
  logic      reset_n;
  logic      req;
  core_cmd_t cmd;
  logic      ack;
  core_rsp_t rsp;

  // reference model of the SRAM contents
  logic [`RV_DATA_W-1:0] shadow [WORDS];
  int seed = 75;
  int cycles = 0;
  int n_checks = 0;
  int n_errors = 0;

  rvseed_mem_top i_rvseed_mem_top (
    .clock   (clock),
    .reset_n (reset_n),
    .req_i   (req),
    .cmd_i   (cmd),
    .ack_o   (ack),
    .rsp_o   (rsp)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // run limit
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [`RV_ADDR_W-1:0] word_addr(input int idx);
    return `RV_MEM_BASE + idx * (`RV_DATA_W / 8);
  endfunction

  function automatic int word_idx(input logic [`RV_ADDR_W-1:0] addr);
    logic [`RV_ADDR_W-1:0] offset;
    offset = addr - `RV_MEM_BASE;
    return int'(offset / (`RV_DATA_W / 8));
  endfunction

  // initial contents, unique per address
  function automatic logic [`RV_DATA_W-1:0] fill_value(input logic [`RV_ADDR_W-1:0] addr);
    return {addr, ~addr};
  endfunction

  function automatic logic [`RV_DATA_W-1:0] rand_dw();
    return {$random(seed), $random(seed)};
  endfunction

  // byte-lane merge of a strobed write
  function automatic logic [`RV_DATA_W-1:0] merge_bytes(input logic [`RV_DATA_W-1:0] old_d,
                                                         input logic [`RV_DATA_W-1:0] new_d,
                                                         input logic [`RV_DATA_W/8-1:0] strb);
    logic [`RV_DATA_W-1:0] res;
    res = old_d;
    for (int b = 0; b < `RV_DATA_W / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_d[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_rsp(input string what, input core_rsp_t got, input core_rsp_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got %h expected %h", what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_e got, input axi_resp_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got %h expected %h", what, got, exp);
    end
  endtask

  task automatic check_ack(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got %h expected %h", what, got, exp);
    end
  endtask

  // four-phase handshake, response taken while ack is high
  task automatic do_cmd(input core_cmd_t c, output core_rsp_t r);
    @(posedge clock);
    cmd <= c;
    req <= 1'b1;
    @(negedge clock);
    while (!ack) begin
      @(negedge clock);
    end
    r = rsp;
    @(posedge clock);
    req <= 1'b0;
    @(negedge clock);
    while (ack) begin
      @(negedge clock);
    end
  endtask

  task automatic write_word(input logic [`RV_ADDR_W-1:0] addr, input logic [`RV_DATA_W-1:0] data,
                            input logic [`RV_DATA_W/8-1:0] strb, input axi_resp_e exp);
    core_cmd_t c;
    core_rsp_t r;
    c = '0;
    c.kind = WRITE_WORD;
    c.addr = addr;
    c.wstrb = strb;
    c.wline[0] = data;
    do_cmd(c, r);
    check_resp($sformatf("rsp_o.resp write %h", addr), r.resp, exp);
    // a rejected write leaves memory alone
    if (exp == OKAY) begin
      shadow[word_idx(addr)] = merge_bytes(shadow[word_idx(addr)], data, strb);
    end
  endtask

  task automatic read_word(input logic [`RV_ADDR_W-1:0] addr, input axi_resp_e exp);
    core_cmd_t c;
    core_rsp_t r;
    core_rsp_t e;
    c = '0;
    c.kind = READ_WORD;
    c.addr = addr;
    do_cmd(c, r);
    if (exp == OKAY) begin
      e = '0;
      e.rline[0] = shadow[word_idx(addr)];
      e.resp = OKAY;
      check_rsp($sformatf("rsp_o read %h", addr), r, e);
    end else begin
      check_resp($sformatf("rsp_o.resp read %h", addr), r.resp, exp);
    end
  endtask

  task automatic write_line(input logic [`RV_ADDR_W-1:0] addr,
                            input logic [`RV_LINE_BEATS-1:0][`RV_DATA_W-1:0] line,
                            input axi_resp_e exp);
    core_cmd_t c;
    core_rsp_t r;
    c = '0;
    c.kind = WRITE_LINE;
    c.addr = addr;
    c.wline = line;
    do_cmd(c, r);
    check_resp($sformatf("rsp_o.resp line write %h", addr), r.resp, exp);
    if (exp == OKAY) begin
      for (int k = 0; k < `RV_LINE_BEATS; k++) begin
        shadow[word_idx(addr) + k] = line[k];
      end
    end
  endtask

  task automatic read_line(input logic [`RV_ADDR_W-1:0] addr, input axi_resp_e exp);
    core_cmd_t c;
    core_rsp_t r;
    core_rsp_t e;
    c = '0;
    c.kind = READ_LINE;
    c.addr = addr;
    do_cmd(c, r);
    if (exp == OKAY) begin
      // beats land in address order
      for (int k = 0; k < `RV_LINE_BEATS; k++) begin
        e.rline[k] = shadow[word_idx(addr) + k];
      end
      e.resp = OKAY;
      check_rsp($sformatf("rsp_o line read %h", addr), r, e);
    end else begin
      check_resp($sformatf("rsp_o.resp line read %h", addr), r.resp, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    $display("test %s: %0d errors", name, n_errors - errs_at_start);
  endtask

  task automatic test_reset_state();
    int start;
    start = n_errors;
    // ack must stay low through reset
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clock);
      check_ack("ack_o during reset", ack, 1'b0);
    end
    @(posedge clock);
    reset_n <= 1'b1;
    repeat (2) begin
      @(negedge clock);
      check_ack("ack_o after reset", ack, 1'b0);
    end
    // first command after reset
    write_word(word_addr(0), rand_dw(), '1, OKAY);
    read_word(word_addr(0), OKAY);
    report_test("reset_state", start);
  endtask

  task automatic fill_memory();
    logic [`RV_LINE_BEATS-1:0][`RV_DATA_W-1:0] line;
    int start;
    start = n_errors;
    for (int l = 0; l < LINES; l++) begin
      for (int k = 0; k < `RV_LINE_BEATS; k++) begin
        line[k] = fill_value(word_addr(l * `RV_LINE_BEATS + k));
      end
      write_line(word_addr(l * `RV_LINE_BEATS), line, OKAY);
    end
    report_test("fill_memory", start);
  endtask

  task automatic test_word_rw();
    logic [`RV_ADDR_W-1:0] addr;
    int start;
    start = n_errors;
    repeat (8) begin
      addr = word_addr({$random(seed)} % WORDS);
      write_word(addr, rand_dw(), '1, OKAY);
      read_word(addr, OKAY);
    end
    report_test("word_rw", start);
  endtask

  task automatic test_partial_strobe();
    logic [`RV_ADDR_W-1:0] addr;
    logic [`RV_DATA_W/8-1:0] strb;
    int start;
    start = n_errors;
    repeat (8) begin
      addr = word_addr({$random(seed)} % WORDS);
      strb = $random(seed);
      write_word(addr, rand_dw(), strb, OKAY);
      read_word(addr, OKAY);
    end
    report_test("partial_strobe", start);
  endtask

  task automatic test_line_rw();
    logic [`RV_LINE_BEATS-1:0][`RV_DATA_W-1:0] line;
    logic [`RV_ADDR_W-1:0] addr;
    int start;
    start = n_errors;
    repeat (4) begin
      addr = word_addr(({$random(seed)} % LINES) * `RV_LINE_BEATS);
      for (int k = 0; k < `RV_LINE_BEATS; k++) begin
        line[k] = rand_dw();
      end
      write_line(addr, line, OKAY);
      read_line(addr, OKAY);
    end
    report_test("line_rw", start);
  endtask

  task automatic test_mixed_sizes();
    logic [`RV_LINE_BEATS-1:0][`RV_DATA_W-1:0] line;
    logic [`RV_ADDR_W-1:0] addr;
    int start;
    start = n_errors;
    addr = word_addr(({$random(seed)} % LINES) * `RV_LINE_BEATS);
    for (int k = 0; k < `RV_LINE_BEATS; k++) begin
      line[k] = rand_dw();
    end
    // line in, words out
    write_line(addr, line, OKAY);
    for (int k = 0; k < `RV_LINE_BEATS; k++) begin
      read_word(addr + k * (`RV_DATA_W / 8), OKAY);
    end
    // words in, line out
    for (int k = 0; k < `RV_LINE_BEATS; k++) begin
      write_word(addr + k * (`RV_DATA_W / 8), rand_dw(), $random(seed), OKAY);
    end
    read_line(addr, OKAY);
    report_test("mixed_sizes", start);
  endtask

  // one rejected write and one rejected read at addr
  task automatic reject_access(input logic [`RV_ADDR_W-1:0] addr, input logic is_line);
    logic [`RV_LINE_BEATS-1:0][`RV_DATA_W-1:0] line;
    for (int k = 0; k < `RV_LINE_BEATS; k++) begin
      line[k] = rand_dw();
    end
    if (is_line) begin
      write_line(addr, line, SLVERR);
      read_line(addr, SLVERR);
    end else begin
      write_word(addr, line[0], '1, SLVERR);
      read_word(addr, SLVERR);
    end
  endtask

  task automatic test_out_of_window();
    int start;
    start = n_errors;
    reject_access(`RV_MEM_BASE - 32'd8, 1'b0);
    reject_access(`RV_MEM_BASE + WIN_BYTES, 1'b0);
    reject_access(`RV_MEM_BASE - 32'd32, 1'b1);
    reject_access(32'hFFFF_FFE0, 1'b1);
    reject_access(32'h0000_0100, 1'b0);
    // whole memory must still match the model
    for (int l = 0; l < LINES; l++) begin
      read_line(word_addr(l * `RV_LINE_BEATS), OKAY);
    end
    report_test("out_of_window", start);
  endtask

  initial begin
    int assert_fails;
    req = 1'b0;
    cmd = '0;
    reset_n = 1'b0;
    test_reset_state();
    fill_memory();
    test_word_rw();
    test_partial_strobe();
    test_line_rw();
    test_mixed_sizes();
    test_out_of_window();
    // protocol violations caught by the bound checker
    assert_fails = i_rvseed_mem_top.i_rvseed_mem_assertions.n_failed;
    $display("%0d checks, %0d errors, %0d assertion failures", n_checks, n_errors,
             assert_fails);
    if (n_errors == 0 && assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
